// File: src/eth_filter_pkg.sv
// Shared widths, depths, filter count and register map of the EtherType receive filter
package eth_filter_pkg;

    // Filter table
    localparam int NUM_FILTERS = 4;
    localparam int ETYPE_W     = 16;

    // Destination and source MAC addresses ahead of the EtherType
    localparam int MAC_HDR_BYTES = 12;

    // Packet byte buffer
    localparam int FIFO_DEPTH = 256;
    localparam int FIFO_AW    = 8;

    // Frames whose verdict may wait for their bytes to reach the FIFO head
    localparam int VERDICT_DEPTH = 4;

    // AXI4-Lite register map
    localparam int AXI_AW = 6;

    // Bit 0 is the global filter enable
    localparam logic [AXI_AW-1:0] ADDR_CTRL = 6'h00;

    // Read-only frame counters
    localparam logic [AXI_AW-1:0] ADDR_ACCEPT_CNT = 6'h04;
    localparam logic [AXI_AW-1:0] ADDR_DROP_CNT   = 6'h08;

    // Entry i sits at base + 4*i, bits 15:0 EtherType, bit 16 valid
    localparam logic [AXI_AW-1:0] ADDR_FILTER_BASE = 6'h10;

endpackage

// File: src/byte_stream_if.sv
// Byte stream interface with data, valid, last and ready, plus source and sink modports
`timescale 1ns/1ps

interface byte_stream_if;

    logic [7:0] data;
    logic       valid;
    logic       last;
    logic       ready;

    // A byte moves when valid and ready are both high
    modport source (
        output data,
        output valid,
        output last,
        input  ready
    );

    modport sink (
        input  data,
        input  valid,
        input  last,
        output ready
    );

endinterface

// File: src/filter_cfg_regs.sv
// AXI4-Lite register block with the filter table, filter enable and frame counters
`timescale 1ns/1ps

module filter_cfg_regs (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [eth_filter_pkg::AXI_AW-1:0]   awaddr,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [31:0]                         wdata,
    input  logic [3:0]                          wstrb,
    input  logic                                wvalid,
    output logic                                wready,
    output logic [1:0]                          bresp,
    output logic                                bvalid,
    input  logic                                bready,
    input  logic [eth_filter_pkg::AXI_AW-1:0]   araddr,
    input  logic                                arvalid,
    output logic                                arready,
    output logic [31:0]                         rdata,
    output logic [1:0]                          rresp,
    output logic                                rvalid,
    input  logic                                rready,
    output logic [eth_filter_pkg::NUM_FILTERS-1:0][eth_filter_pkg::ETYPE_W-1:0] filter_etype,
    output logic [eth_filter_pkg::NUM_FILTERS-1:0] filter_valid,
    output logic                                filter_enable,
    input  logic                                frame_accepted,
    input  logic                                frame_dropped
);

    logic        wr_fire;
    logic        rd_fire;
    logic [31:0] accept_cnt;
    logic [31:0] drop_cnt;
    logic [31:0] rd_mux;

    // Address of filter entry idx
    function automatic logic [eth_filter_pkg::AXI_AW-1:0] filter_addr(input int idx);
        logic [31:0] full;
        full = 32'(eth_filter_pkg::ADDR_FILTER_BASE) + 32'(4 * idx);
        return full[eth_filter_pkg::AXI_AW-1:0];
    endfunction

    assign wready  = awready;
    assign wr_fire = awready && awvalid && wvalid;
    assign rd_fire = arready && arvalid;
    assign bresp   = 2'b00;
    assign rresp   = 2'b00;

    // Handshake and response channels
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            awready <= 1'b0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            awready <= awvalid && wvalid && !bvalid && !awready;
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            arready <= arvalid && !arready && !rvalid;
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Control bits, valid flags and counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            filter_enable <= 1'b1;
            filter_valid  <= '0;
            accept_cnt    <= '0;
            drop_cnt      <= '0;
        end else begin
            if (wr_fire && awaddr == eth_filter_pkg::ADDR_CTRL && wstrb[0]) begin
                filter_enable <= wdata[0];
            end
            for (int i = 0; i < eth_filter_pkg::NUM_FILTERS; i++) begin
                if (wr_fire && awaddr == filter_addr(i) && wstrb[2]) begin
                    filter_valid[i] <= wdata[16];
                end
            end
            if (frame_accepted) begin
                accept_cnt <= accept_cnt + 32'd1;
            end
            if (frame_dropped) begin
                drop_cnt <= drop_cnt + 32'd1;
            end
        end
    end

    // EtherType fields written byte by byte under the strobes
    always_ff @(posedge clk) begin
        for (int i = 0; i < eth_filter_pkg::NUM_FILTERS; i++) begin
            if (wr_fire && awaddr == filter_addr(i)) begin
                if (wstrb[0]) filter_etype[i][7:0] <= wdata[7:0];
                if (wstrb[1]) filter_etype[i][15:8] <= wdata[15:8];
            end
        end
    end

    // Unmapped addresses read as zero
    always_comb begin
        rd_mux = '0;
        case (araddr)
            eth_filter_pkg::ADDR_CTRL:       rd_mux = {31'd0, filter_enable};
            eth_filter_pkg::ADDR_ACCEPT_CNT: rd_mux = accept_cnt;
            eth_filter_pkg::ADDR_DROP_CNT:   rd_mux = drop_cnt;
            default:                         rd_mux = '0;
        endcase
        for (int i = 0; i < eth_filter_pkg::NUM_FILTERS; i++) begin
            if (araddr == filter_addr(i)) begin
                rd_mux = {{(31 - eth_filter_pkg::ETYPE_W){1'b0}},
                          filter_valid[i], filter_etype[i]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_mux;
        end
    end

endmodule

// File: src/ethertype_matcher.sv
// Header byte counter, EtherType capture, parallel filter compare, verdict and byte pass-through
`timescale 1ns/1ps

module ethertype_matcher (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [7:0]                          rx_data,
    input  logic                                rx_valid,
    input  logic                                rx_start,
    input  logic                                rx_end,
    input  logic [eth_filter_pkg::NUM_FILTERS-1:0][eth_filter_pkg::ETYPE_W-1:0] filter_etype,
    input  logic [eth_filter_pkg::NUM_FILTERS-1:0] filter_valid,
    input  logic                                filter_enable,
    byte_stream_if.source                       wr_link,
    output logic                                verdict_valid,
    output logic                                verdict_accept,
    output logic [eth_filter_pkg::NUM_FILTERS-1:0] verdict_match
);

    // One-hot frame position
    logic in_hdr;
    logic in_eth_hi;
    logic in_eth_lo;
    logic in_payload;

    logic [3:0]                            hdr_cnt;
    logic [eth_filter_pkg::ETYPE_W-1:0]    etype;
    logic                                  end_d1;
    logic                                  end_d2;
    logic [eth_filter_pkg::NUM_FILTERS-1:0] hits;
    logic [eth_filter_pkg::NUM_FILTERS-1:0] match_q;

    // The start byte counts as header byte 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_hdr     <= 1'b1;
            in_eth_hi  <= 1'b0;
            in_eth_lo  <= 1'b0;
            in_payload <= 1'b0;
            hdr_cnt    <= '0;
        end else if (rx_valid) begin
            if (rx_start) begin
                in_hdr     <= 1'b1;
                in_eth_hi  <= 1'b0;
                in_eth_lo  <= 1'b0;
                in_payload <= 1'b0;
                hdr_cnt    <= 4'd1;
            end else begin
                if (in_hdr) begin
                    hdr_cnt <= hdr_cnt + 4'd1;
                    if (hdr_cnt == 4'(eth_filter_pkg::MAC_HDR_BYTES - 1)) begin
                        in_hdr    <= 1'b0;
                        in_eth_hi <= 1'b1;
                    end
                end
                if (in_eth_hi) begin
                    in_eth_hi <= 1'b0;
                    in_eth_lo <= 1'b1;
                end
                if (in_eth_lo) begin
                    in_eth_lo  <= 1'b0;
                    in_payload <= 1'b1;
                end
            end
        end
    end

    // EtherType bytes 12 and 13
    always_ff @(posedge clk) begin
        if (rx_valid && !rx_start && in_eth_hi) begin
            etype[15:8] <= rx_data;
        end
        if (rx_valid && !rx_start && in_eth_lo) begin
            etype[7:0] <= rx_data;
        end
    end

    always_comb begin
        for (int i = 0; i < eth_filter_pkg::NUM_FILTERS; i++) begin
            hits[i] = filter_valid[i] && (etype == filter_etype[i]);
        end
    end

    // Verdict lands two edges after the last byte
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            end_d1        <= 1'b0;
            end_d2        <= 1'b0;
            verdict_valid <= 1'b0;
            wr_link.valid <= 1'b0;
        end else begin
            end_d1        <= rx_valid && rx_end;
            end_d2        <= end_d1;
            verdict_valid <= end_d2;
            wr_link.valid <= rx_valid;
        end
    end

    // Short frames never reach the payload and report no hit
    always_ff @(posedge clk) begin
        match_q        <= in_payload ? hits : '0;
        verdict_match  <= match_q;
        verdict_accept <= !filter_enable || (|match_q);
        wr_link.data   <= rx_data;
        wr_link.last   <= rx_end;
    end

endmodule

// File: src/packet_byte_fifo.sv
// First-word fall-through FIFO of frame bytes, each stored with its last flag
`timescale 1ns/1ps

module packet_byte_fifo (
    input  logic          clk,
    input  logic          rst_n,
    byte_stream_if.sink   wr_link,
    byte_stream_if.source rd_link
);

    logic [8:0]                        mem [eth_filter_pkg::FIFO_DEPTH];
    logic [eth_filter_pkg::FIFO_AW:0]  wr_ptr;
    logic [eth_filter_pkg::FIFO_AW:0]  rd_ptr;
    logic                              empty;
    logic                              full;
    logic                              rd_fire;

    // The top bit of each pointer tells a full buffer from an empty one
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[eth_filter_pkg::FIFO_AW] != rd_ptr[eth_filter_pkg::FIFO_AW]) &&
                   (wr_ptr[eth_filter_pkg::FIFO_AW-1:0] == rd_ptr[eth_filter_pkg::FIFO_AW-1:0]);

    // Every valid byte is written whatever ready shows
    assign wr_link.ready = !full;

    assign rd_link.valid = !empty;
    assign rd_link.data  = mem[rd_ptr[eth_filter_pkg::FIFO_AW-1:0]][7:0];
    assign rd_link.last  = mem[rd_ptr[eth_filter_pkg::FIFO_AW-1:0]][8];
    assign rd_fire       = rd_link.valid && rd_link.ready;

    always_ff @(posedge clk) begin
        if (wr_link.valid) begin
            mem[wr_ptr[eth_filter_pkg::FIFO_AW-1:0]] <= {wr_link.last, wr_link.data};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_link.valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// File: src/packet_forwarder.sv
// Verdict queue and the forward or discard logic for the frame at the FIFO head
`timescale 1ns/1ps

module packet_forwarder (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   verdict_valid,
    input  logic                                   verdict_accept,
    input  logic [eth_filter_pkg::NUM_FILTERS-1:0] verdict_match,
    byte_stream_if.sink                            rd_link,
    output logic [7:0]                             tx_data,
    output logic                                   tx_valid,
    output logic                                   tx_last,
    output logic [eth_filter_pkg::NUM_FILTERS-1:0] tx_match,
    input  logic                                   tx_ready,
    output logic                                   frame_accepted,
    output logic                                   frame_dropped
);

    logic                                   vq_accept [eth_filter_pkg::VERDICT_DEPTH];
    logic [eth_filter_pkg::NUM_FILTERS-1:0] vq_match  [eth_filter_pkg::VERDICT_DEPTH];
    logic [$clog2(eth_filter_pkg::VERDICT_DEPTH)-1:0] wr_idx;
    logic [$clog2(eth_filter_pkg::VERDICT_DEPTH)-1:0] rd_idx;
    logic                                   wr_wrap;
    logic                                   rd_wrap;
    logic                                   have_verdict;
    logic                                   head_accept;
    logic                                   frame_done;

    assign have_verdict = !((wr_idx == rd_idx) && (wr_wrap == rd_wrap));
    assign head_accept  = vq_accept[rd_idx];

    // Dropped frames drain at full rate, accepted ones follow tx_ready
    assign rd_link.ready = have_verdict && (head_accept ? tx_ready : 1'b1);

    assign tx_valid = have_verdict && head_accept && rd_link.valid;
    assign tx_data  = rd_link.data;
    assign tx_last  = rd_link.last;
    assign tx_match = vq_match[rd_idx];

    assign frame_done     = rd_link.valid && rd_link.ready && rd_link.last;
    assign frame_accepted = frame_done && head_accept;
    assign frame_dropped  = frame_done && !head_accept;

    always_ff @(posedge clk) begin
        if (verdict_valid) begin
            vq_accept[wr_idx] <= verdict_accept;
            vq_match[wr_idx]  <= verdict_match;
        end
    end

    // Push per verdict pulse, pop when the head frame's last byte leaves
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_idx  <= '0;
            wr_wrap <= 1'b0;
            rd_idx  <= '0;
            rd_wrap <= 1'b0;
        end else begin
            if (verdict_valid) begin
                {wr_wrap, wr_idx} <= {wr_wrap, wr_idx} + 1'b1;
            end
            if (frame_done) begin
                {rd_wrap, rd_idx} <= {rd_wrap, rd_idx} + 1'b1;
            end
        end
    end

endmodule

// File: src/eth_filter_top.sv
// Top level of the EtherType receive filter with the register block, matcher, FIFO and forwarder
`timescale 1ns/1ps

module eth_filter_top (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [7:0]                             rx_data,
    input  logic                                   rx_valid,
    input  logic                                   rx_start,
    input  logic                                   rx_end,
    output logic [7:0]                             tx_data,
    output logic                                   tx_valid,
    output logic                                   tx_last,
    output logic [eth_filter_pkg::NUM_FILTERS-1:0] tx_match,
    input  logic                                   tx_ready,
    input  logic [eth_filter_pkg::AXI_AW-1:0]      awaddr,
    input  logic                                   awvalid,
    output logic                                   awready,
    input  logic [31:0]                            wdata,
    input  logic [3:0]                             wstrb,
    input  logic                                   wvalid,
    output logic                                   wready,
    output logic [1:0]                             bresp,
    output logic                                   bvalid,
    input  logic                                   bready,
    input  logic [eth_filter_pkg::AXI_AW-1:0]      araddr,
    input  logic                                   arvalid,
    output logic                                   arready,
    output logic [31:0]                            rdata,
    output logic [1:0]                             rresp,
    output logic                                   rvalid,
    input  logic                                   rready
);

    logic [eth_filter_pkg::NUM_FILTERS-1:0][eth_filter_pkg::ETYPE_W-1:0] filter_etype;
    logic [eth_filter_pkg::NUM_FILTERS-1:0] filter_valid;
    logic                                   filter_enable;
    logic                                   verdict_valid;
    logic                                   verdict_accept;
    logic [eth_filter_pkg::NUM_FILTERS-1:0] verdict_match;
    logic                                   frame_accepted;
    logic                                   frame_dropped;

    byte_stream_if wr_link ();
    byte_stream_if rd_link ();

    filter_cfg_regs u_regs (
        .clk(clk), .rst_n(rst_n),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .filter_etype(filter_etype), .filter_valid(filter_valid),
        .filter_enable(filter_enable),
        .frame_accepted(frame_accepted), .frame_dropped(frame_dropped)
    );

    ethertype_matcher u_matcher (
        .clk(clk), .rst_n(rst_n),
        .rx_data(rx_data), .rx_valid(rx_valid), .rx_start(rx_start), .rx_end(rx_end),
        .filter_etype(filter_etype), .filter_valid(filter_valid),
        .filter_enable(filter_enable),
        .wr_link(wr_link.source),
        .verdict_valid(verdict_valid), .verdict_accept(verdict_accept),
        .verdict_match(verdict_match)
    );

    packet_byte_fifo u_fifo (
        .clk(clk), .rst_n(rst_n),
        .wr_link(wr_link.sink),
        .rd_link(rd_link.source)
    );

    packet_forwarder u_forwarder (
        .clk(clk), .rst_n(rst_n),
        .verdict_valid(verdict_valid), .verdict_accept(verdict_accept),
        .verdict_match(verdict_match),
        .rd_link(rd_link.sink),
        .tx_data(tx_data), .tx_valid(tx_valid), .tx_last(tx_last),
        .tx_match(tx_match), .tx_ready(tx_ready),
        .frame_accepted(frame_accepted), .frame_dropped(frame_dropped)
    );

endmodule

// File: dv/eth_filter_tb.sv
// Testbench for the EtherType receive filter with AXI tasks, frame stimulus, reference queue and checks
`timescale 1ns/1ps

module eth_filter_tb;

    localparam int NF          = eth_filter_pkg::NUM_FILTERS;
    localparam int MIN_LEN     = 14;
    localparam int MAX_LEN     = 60;
    localparam int RAND_FRAMES = 20;
    // Directed frame bytes in tests 2 to 4
    localparam int FIXED_BYTES     = 321;
    localparam int WATCHDOG_CYCLES = (FIXED_BYTES + RAND_FRAMES * MAX_LEN) * 4 + 2000;

    // Expected register map
    localparam logic [5:0] REG_CTRL     = 6'h00;
    localparam logic [5:0] REG_ACCEPT   = 6'h04;
    localparam logic [5:0] REG_DROP     = 6'h08;
    localparam logic [5:0] REG_UNMAPPED = 6'h0C;
    localparam logic [5:0] REG_FILTER0  = 6'h10;

    logic          clk = 1'b0;
    logic          rst_n;
    logic [7:0]    rx_data;
    logic          rx_valid;
    logic          rx_start;
    logic          rx_end;
    logic [7:0]    tx_data;
    logic          tx_valid;
    logic          tx_last;
    logic [NF-1:0] tx_match;
    logic          tx_ready;
    logic [5:0]    awaddr;
    logic          awvalid;
    logic          awready;
    logic [31:0]   wdata;
    logic [3:0]    wstrb;
    logic          wvalid;
    logic          wready;
    logic [1:0]    bresp;
    logic          bvalid;
    logic          bready;
    logic [5:0]    araddr;
    logic          arvalid;
    logic          arready;
    logic [31:0]   rdata;
    logic [1:0]    rresp;
    logic          rvalid;
    logic          rready;

    // Reference model of the filter table and expected output bytes
    logic [15:0]   model_etype [NF];
    logic          model_valid [NF];
    logic          model_enable;
    logic [7:0]    exp_data [$];
    logic          exp_last [$];
    logic [NF-1:0] exp_match [$];
    int            exp_accepts = 0;
    int            exp_drops = 0;
    int            frames_sent = 0;
    int            frames_done = 0;
    int            checks = 0;
    int            errors = 0;
    logic [31:0]   stim_seed = 32'd14597;
    logic [31:0]   ready_seed = 32'd14597;
    logic          stall_en = 1'b0;
    int            stall_left = 0;
    logic          hold_valid = 1'b0;
    logic [7:0]    hold_data;
    logic          hold_last;
    logic [NF-1:0] hold_match;

    eth_filter_top UUT (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("CHECK FAILED t=%0t %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic axi_write(input logic [5:0] addr, input logic [31:0] data);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hF;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        compare("wready", 1, wready);
        @(posedge clk);
        #5;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        compare("bresp", 0, bresp);
        @(posedge clk);
        #5;
    endtask

    task automatic axi_read(input logic [5:0] addr, output logic [31:0] data);
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        #5;
        arvalid = 1'b0;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        compare("rresp", 0, rresp);
        data = rdata;
        @(posedge clk);
        #5;
    endtask

    task automatic check_reg(input string name, input logic [5:0] addr,
                             input logic [31:0] expected);
        logic [31:0] got;
        axi_read(addr, got);
        compare(name, expected, got);
    endtask

    task automatic set_filter(input int idx, input logic [15:0] etype, input logic valid);
        axi_write(REG_FILTER0 + 6'(4 * idx), {15'd0, valid, etype});
        model_etype[idx] = etype;
        model_valid[idx] = valid;
    endtask

    task automatic set_enable(input logic en);
        axi_write(REG_CTRL, {31'd0, en});
        model_enable = en;
    endtask

    task automatic set_stalls(input logic en);
        @(negedge clk);
        stall_en = en;
        @(posedge clk);
        #5;
    endtask

    // At most VERDICT_DEPTH frames in flight keeps the FIFO and verdict queue from overflowing
    task automatic send_frame(input int len, input logic [15:0] etype);
        logic [NF-1:0] mask;
        logic          accept;
        logic [7:0]    b;
        while (frames_sent - frames_done >= eth_filter_pkg::VERDICT_DEPTH) begin
            @(posedge clk);
            #5;
        end
        mask = '0;
        for (int i = 0; i < NF; i++) begin
            if (len >= MIN_LEN && model_valid[i] && model_etype[i] == etype) begin
                mask[i] = 1'b1;
            end
        end
        accept = !model_enable || (mask != '0);
        frames_sent++;
        if (accept) begin
            exp_accepts++;
        end else begin
            exp_drops++;
        end
        for (int i = 0; i < len; i++) begin
            if (i == 12) begin
                b = etype[15:8];
            end else if (i == 13) begin
                b = etype[7:0];
            end else begin
                stim_seed = lcg(stim_seed);
                b = stim_seed[23:16];
            end
            if (accept) begin
                exp_data.push_back(b);
                exp_last.push_back(i == len - 1);
                exp_match.push_back(mask);
            end
            rx_data  = b;
            rx_valid = 1'b1;
            rx_start = (i == 0);
            rx_end   = (i == len - 1);
            @(posedge clk);
            #5;
        end
        rx_valid = 1'b0;
        rx_start = 1'b0;
        rx_end   = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_data.size() != 0 || frames_sent != frames_done) begin
            @(posedge clk);
            #5;
        end
    endtask

    task automatic report_test(input string name, input int err_mark);
        $display("Test %s finished with %0d errors", name, errors - err_mark);
    endtask

    // Random tx_ready stalls of 1 to 3 cycles
    always @(posedge clk) begin
        #5;
        if (!stall_en) begin
            tx_ready = 1'b1;
        end else if (stall_left != 0) begin
            tx_ready = 1'b0;
            stall_left--;
        end else begin
            ready_seed = lcg(ready_seed);
            if (ready_seed[17:16] == 2'd0) begin
                tx_ready   = 1'b0;
                stall_left = int'(ready_seed[23:18] % 3);
            end else begin
                tx_ready = 1'b1;
            end
        end
    end

    // Transfers seen here complete at the next rising edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (hold_valid) begin
                compare("tx_valid in stall", 1, tx_valid);
                compare("tx_data in stall", hold_data, tx_data);
                compare("tx_last in stall", hold_last, tx_last);
                compare("tx_match in stall", hold_match, tx_match);
            end
            if (tx_valid) begin
                if (exp_data.size() == 0) begin
                    errors++;
                    $display("Unexpected tx_valid at t=%0t with no accepted frame pending", $time);
                end else if (tx_ready) begin
                    compare("tx_data", exp_data[0], tx_data);
                    compare("tx_last", exp_last[0], tx_last);
                    compare("tx_match", exp_match[0], tx_match);
                    void'(exp_data.pop_front());
                    void'(exp_last.pop_front());
                    void'(exp_match.pop_front());
                end
            end
            if (UUT.frame_accepted || UUT.frame_dropped) begin
                frames_done++;
            end
            hold_valid = tx_valid && !tx_ready;
            hold_data  = tx_data;
            hold_last  = tx_last;
            hold_match = tx_match;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the tests completed", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int          err_mark;
        int          len;
        logic [15:0] et;
        rst_n = 1'b0;
        rx_data = '0;
        rx_valid = 1'b0;
        rx_start = 1'b0;
        rx_end = 1'b0;
        tx_ready = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b1;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b1;
        model_enable = 1'b1;
        for (int i = 0; i < NF; i++) begin
            model_etype[i] = '0;
            model_valid[i] = 1'b0;
        end
        repeat (10) @(posedge clk);
        #5;
        rst_n = 1'b1;
        @(posedge clk);
        #5;

        err_mark = errors;
        check_reg("ctrl", REG_CTRL, 32'h1);
        check_reg("accept_cnt", REG_ACCEPT, 32'h0);
        check_reg("drop_cnt", REG_DROP, 32'h0);
        check_reg("unmapped", REG_UNMAPPED, 32'h0);
        set_filter(0, 16'h0800, 1'b1);
        set_filter(1, 16'h86DD, 1'b1);
        set_filter(2, 16'h0806, 1'b1);
        set_filter(3, 16'h88B5, 1'b0);
        for (int i = 0; i < NF; i++) begin
            check_reg("filter entry", REG_FILTER0 + 6'(4 * i),
                      {15'd0, model_valid[i], model_etype[i]});
        end
        report_test("register access", err_mark);

        err_mark = errors;
        send_frame(40, 16'h0800);
        send_frame(42, 16'h0806);
        send_frame(60, 16'h86DD);
        send_frame(50, 16'h88CC);
        send_frame(30, 16'h88B5);
        wait_drained();
        report_test("ethertype pass and drop", err_mark);

        err_mark = errors;
        send_frame(10, 16'h0800);
        send_frame(14, 16'h0800);
        wait_drained();
        report_test("short frames", err_mark);

        err_mark = errors;
        set_enable(1'b0);
        send_frame(30, 16'h88CC);
        send_frame(20, 16'h0806);
        send_frame(25, 16'h88B5);
        wait_drained();
        set_enable(1'b1);
        report_test("filtering disabled", err_mark);

        err_mark = errors;
        set_stalls(1'b1);
        for (int n = 0; n < RAND_FRAMES; n++) begin
            stim_seed = lcg(stim_seed);
            len = MIN_LEN + int'(stim_seed[23:16] % (MAX_LEN - MIN_LEN + 1));
            case (stim_seed[27:25] % 5)
                0: et = 16'h0800;
                1: et = 16'h86DD;
                2: et = 16'h0806;
                3: et = 16'h88CC;
                default: et = 16'h88B5;
            endcase
            send_frame(len, et);
        end
        wait_drained();
        set_stalls(1'b0);
        report_test("back-pressure", err_mark);

        err_mark = errors;
        check_reg("accept_cnt", REG_ACCEPT, 32'(exp_accepts));
        check_reg("drop_cnt", REG_DROP, 32'(exp_drops));
        report_test("counters", err_mark);

        $display("Summary: %0d checks, %0d errors, %0d frames accepted, %0d frames dropped",
                 checks, errors, exp_accepts, exp_drops);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
src/eth_filter_pkg.sv
src/byte_stream_if.sv
src/filter_cfg_regs.sv
src/ethertype_matcher.sv
src/packet_byte_fifo.sv
src/packet_forwarder.sv
src/eth_filter_top.sv
dv/eth_filter_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the EtherType filter testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module eth_filter_tb -f tb.f -o sim_eth_filter &&
sim_out="$(./obj_dir/sim_eth_filter)" &&
echo "$sim_out" &&
grep -q "TESTBENCH PASSED" <<< "$sim_out" &&
echo "Simulation result: pass" ||
{ echo "Simulation result: fail"; exit 1; }
